// ==== include/ir_settings.svh ====
// ----------------------------------------
// widths, lane count and RV32 opcode values
// for the instruction register stage
// ----------------------------------------
`ifndef IR_SETTINGS_SVH
`define IR_SETTINGS_SVH

`define IR_XLEN   32
`define IR_REG_AW 5
`define IR_LANES  2

// major opcodes, instr[6:0]
`define IR_OPC_OP     7'b0110011
`define IR_OPC_OP_IMM 7'b0010011
`define IR_OPC_LOAD   7'b0000011
`define IR_OPC_STORE  7'b0100011
`define IR_OPC_BRANCH 7'b1100011
`define IR_OPC_LUI    7'b0110111
`define IR_OPC_JAL    7'b1101111

`endif

// ==== verilog/ir_pkg.sv ====
// ----------------------------------------
// shared types of the instruction register
// stage: vector typedefs, class enum and
// packed record widths
// ----------------------------------------
`include "ir_settings.svh"

package ir_pkg;

  typedef logic [`IR_XLEN-1:0]   xlen_t;
  typedef logic [`IR_XLEN-1:0]   pc_t;
  typedef logic [31:0]           instr_t;
  typedef logic [`IR_REG_AW-1:0] reg_addr_t;
  typedef logic [`IR_LANES-1:0]  lane_mask_t;

  typedef enum logic [2:0] {
    OP_REG     = 3'd0,
    OP_IMM     = 3'd1,
    OP_LOAD    = 3'd2,
    OP_STORE   = 3'd3,
    OP_BRANCH  = 3'd4,
    OP_LUI     = 3'd5,
    OP_JAL     = 3'd6,
    OP_ILLEGAL = 3'd7
  } op_class_e;

  // fetch slot is {pc, instr}, decoded record is {pc, rs1, rs2, rd, rd_we, class}
  localparam int unsigned ir_slot_w = $bits(pc_t) + $bits(instr_t);
  localparam int unsigned ir_dec_w  = $bits(pc_t) + 3 * $bits(reg_addr_t) + 1 +
                                      $bits(op_class_e);

endpackage

// ==== verilog/ir_pair_fifo.sv ====
// ----------------------------------------
// two-entry pair buffer with dual write and
// dual read, both physical entries exposed
// ----------------------------------------
`timescale 1ns/100ps

module ir_pair_fifo #(
  parameter int unsigned Width = 32
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,

  input  ir_pkg::lane_mask_t wr_valid_i,
  input  logic [Width-1:0]   wr_data0_i,
  input  logic [Width-1:0]   wr_data1_i,
  output ir_pkg::lane_mask_t wr_rdy_o,

  input  ir_pkg::lane_mask_t rd_rdy_i,
  output ir_pkg::lane_mask_t rd_valid_o,
  output logic [Width-1:0]   mema_o,
  output logic [Width-1:0]   memb_o,
  output logic               mema_is0_o,

  output ir_pkg::lane_mask_t wr_mema_o,
  output ir_pkg::lane_mask_t wr_memb_o
);
  import ir_pkg::*;

  logic [Width-1:0] mem_q [2];
  logic [1:0]       vld_q;
  logic [1:0]       vld_d;
  logic             wr_ptr_q;
  logic             rd_ptr_q;
  lane_mask_t       wr_take;
  lane_mask_t       rd_take;
  logic [1:0]       wr_ent;
  logic [1:0]       rd_ent;

  // thermometers from occupancy only
  assign wr_rdy_o   = {~|vld_q, ~&vld_q};
  assign rd_valid_o = {&vld_q, |vld_q};

  assign wr_take = wr_valid_i & wr_rdy_o;
  assign rd_take = rd_rdy_i & rd_valid_o;

  // lane 0 goes where wr_ptr points, lane 1 into the other entry
  assign wr_mema_o = {wr_take[1] & wr_ptr_q, wr_take[0] & ~wr_ptr_q};
  assign wr_memb_o = {wr_take[1] & ~wr_ptr_q, wr_take[0] & wr_ptr_q};
  assign wr_ent    = {|wr_memb_o, |wr_mema_o};

  // oldest entry sits at rd_ptr
  assign rd_ent[0] = (rd_take[0] & ~rd_ptr_q) | (rd_take[1] & rd_ptr_q);
  assign rd_ent[1] = (rd_take[0] & rd_ptr_q) | (rd_take[1] & ~rd_ptr_q);

  assign vld_d = (vld_q & ~rd_ent) | wr_ent;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q    <= 2'b00;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else if (flush_i) begin
      vld_q    <= 2'b00;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      vld_q    <= vld_d;
      // a single transfer moves the pointer by one entry
      wr_ptr_q <= wr_ptr_q ^ (wr_take[0] ^ wr_take[1]);
      rd_ptr_q <= rd_ptr_q ^ (rd_take[0] ^ rd_take[1]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_mema_o[0]) begin
      mem_q[0] <= wr_data0_i;
    end else if (wr_mema_o[1]) begin
      mem_q[0] <= wr_data1_i;
    end
    if (wr_memb_o[0]) begin
      mem_q[1] <= wr_data0_i;
    end else if (wr_memb_o[1]) begin
      mem_q[1] <= wr_data1_i;
    end
  end

  assign mema_o     = mem_q[0];
  assign memb_o     = mem_q[1];
  assign mema_is0_o = ~rd_ptr_q;

endmodule

// ==== verilog/ir_field_decoder.sv ====
// ----------------------------------------
// register field extraction and opcode
// classification for one instruction
// ----------------------------------------
`timescale 1ns/100ps
`include "ir_settings.svh"

module ir_field_decoder (
  input  ir_pkg::instr_t    instr_i,
  output ir_pkg::reg_addr_t rs1_o,
  output ir_pkg::reg_addr_t rs2_o,
  output ir_pkg::reg_addr_t rd_o,
  output logic              rd_we_o,
  output ir_pkg::op_class_e op_class_o
);
  import ir_pkg::*;

  logic use_rs1;
  logic use_rs2;
  logic use_rd;

  always_comb begin
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    use_rd     = 1'b0;
    op_class_o = OP_ILLEGAL;
    case (instr_i[6:0])
      `IR_OPC_OP: begin
        op_class_o = OP_REG;
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
        use_rd     = 1'b1;
      end
      `IR_OPC_OP_IMM: begin
        op_class_o = OP_IMM;
        use_rs1    = 1'b1;
        use_rd     = 1'b1;
      end
      `IR_OPC_LOAD: begin
        op_class_o = OP_LOAD;
        use_rs1    = 1'b1;
        use_rd     = 1'b1;
      end
      `IR_OPC_STORE: begin
        op_class_o = OP_STORE;
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
      end
      `IR_OPC_BRANCH: begin
        op_class_o = OP_BRANCH;
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
      end
      `IR_OPC_LUI: begin
        op_class_o = OP_LUI;
        use_rd     = 1'b1;
      end
      `IR_OPC_JAL: begin
        op_class_o = OP_JAL;
        use_rd     = 1'b1;
      end
      default: begin
        op_class_o = OP_ILLEGAL;
      end
    endcase
  end

  // unused fields read as x0
  assign rs1_o   = use_rs1 ? instr_i[19:15] : '0;
  assign rs2_o   = use_rs2 ? instr_i[24:20] : '0;
  assign rd_o    = use_rd ? instr_i[11:7] : '0;
  assign rd_we_o = use_rd & (|instr_i[11:7]);

endmodule

// ==== verilog/ir_operand_hold.sv ====
// ----------------------------------------
// operand pair register for one output
// buffer entry, capture and write bypass
// ----------------------------------------
`timescale 1ns/100ps

module ir_operand_hold (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  ir_pkg::lane_mask_t wr_mem_i,

  input  ir_pkg::reg_addr_t  rs1_l0_i,
  input  ir_pkg::reg_addr_t  rs2_l0_i,
  input  ir_pkg::reg_addr_t  rs1_l1_i,
  input  ir_pkg::reg_addr_t  rs2_l1_i,
  input  ir_pkg::xlen_t      rdata0_l0_i,
  input  ir_pkg::xlen_t      rdata1_l0_i,
  input  ir_pkg::xlen_t      rdata0_l1_i,
  input  ir_pkg::xlen_t      rdata1_l1_i,

  input  ir_pkg::reg_addr_t  waddr0_i,
  input  ir_pkg::reg_addr_t  waddr1_i,
  input  ir_pkg::reg_addr_t  waddr2_i,
  input  ir_pkg::xlen_t      wdata0_i,
  input  ir_pkg::xlen_t      wdata1_i,
  input  ir_pkg::xlen_t      wdata2_i,
  input  logic               we0_i,
  input  logic               we1_i,
  input  logic               we2_i,

  output ir_pkg::xlen_t      op0_o,
  output ir_pkg::xlen_t      op1_o
);
  import ir_pkg::*;

  reg_addr_t addr0_q;
  reg_addr_t addr1_q;
  reg_addr_t addr0;
  reg_addr_t addr1;
  xlen_t     op0_q;
  xlen_t     op1_q;
  xlen_t     keep0;
  xlen_t     keep1;
  logic      capture;

  // port 2 has the newest value, then 1, then 0
  function automatic xlen_t pick_operand(input reg_addr_t addr, input xlen_t keep);
    xlen_t res;
    res = keep;
    if (we2_i && (waddr2_i == addr)) begin
      res = wdata2_i;
    end else if (we1_i && (waddr1_i == addr)) begin
      res = wdata1_i;
    end else if (we0_i && (waddr0_i == addr)) begin
      res = wdata0_i;
    end
    return res;
  endfunction

  assign capture = |wr_mem_i;

  // lane 0 wins if both mask bits were ever set
  assign addr0 = !capture ? addr0_q : (wr_mem_i[0] ? rs1_l0_i : rs1_l1_i);
  assign addr1 = !capture ? addr1_q : (wr_mem_i[0] ? rs2_l0_i : rs2_l1_i);
  assign keep0 = !capture ? op0_q : (wr_mem_i[0] ? rdata0_l0_i : rdata0_l1_i);
  assign keep1 = !capture ? op1_q : (wr_mem_i[0] ? rdata1_l0_i : rdata1_l1_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr0_q <= '0;
      addr1_q <= '0;
      op0_q   <= '0;
      op1_q   <= '0;
    end else begin
      addr0_q <= addr0;
      addr1_q <= addr1;
      op0_q   <= pick_operand(addr0, keep0);
      op1_q   <= pick_operand(addr1, keep1);
    end
  end

  assign op0_o = op0_q;
  assign op1_o = op1_q;

endmodule

// ==== verilog/ir_stage.sv ====
// ----------------------------------------
// dual-issue instruction register stage:
// fetch buffer, decoders, decoded buffer,
// operand holds and regfile read addresses
// ----------------------------------------
`timescale 1ns/100ps

module ir_stage (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ir_flush_i,

  input  ir_pkg::lane_mask_t us_valid_i,
  input  ir_pkg::pc_t        us_pc0_i,
  input  ir_pkg::pc_t        us_pc1_i,
  input  ir_pkg::instr_t     us_instr0_i,
  input  ir_pkg::instr_t     us_instr1_i,
  output ir_pkg::lane_mask_t ir_rdy_o,

  output ir_pkg::reg_addr_t  rf_raddr_p0_o [2],
  output ir_pkg::reg_addr_t  rf_raddr_p1_o [2],
  input  ir_pkg::xlen_t      rf_rdata_p0_i [2],
  input  ir_pkg::xlen_t      rf_rdata_p1_i [2],
  input  ir_pkg::reg_addr_t  rf_waddr0_i,
  input  ir_pkg::xlen_t      rf_wdata0_i,
  input  logic               rf_we0_i,
  input  ir_pkg::reg_addr_t  rf_waddr1_i,
  input  ir_pkg::xlen_t      rf_wdata1_i,
  input  logic               rf_we1_i,
  input  ir_pkg::reg_addr_t  rf_waddr2_i,
  input  ir_pkg::xlen_t      rf_wdata2_i,
  input  logic               rf_we2_i,

  input  ir_pkg::lane_mask_t ds_rdy_i,
  output ir_pkg::lane_mask_t ir_valid_o,
  output logic               ira_is0_o,
  output ir_pkg::pc_t        ira_pc_o,
  output ir_pkg::reg_addr_t  ira_rs1_o,
  output ir_pkg::reg_addr_t  ira_rs2_o,
  output ir_pkg::reg_addr_t  ira_rd_o,
  output logic               ira_rd_we_o,
  output ir_pkg::op_class_e  ira_class_o,
  output ir_pkg::pc_t        irb_pc_o,
  output ir_pkg::reg_addr_t  irb_rs1_o,
  output ir_pkg::reg_addr_t  irb_rs2_o,
  output ir_pkg::reg_addr_t  irb_rd_o,
  output logic               irb_rd_we_o,
  output ir_pkg::op_class_e  irb_class_o,
  output ir_pkg::xlen_t      ira_op0_o,
  output ir_pkg::xlen_t      ira_op1_o,
  output ir_pkg::xlen_t      irb_op0_o,
  output ir_pkg::xlen_t      irb_op1_o
);
  import ir_pkg::*;

  logic [ir_slot_w-1:0] s0_mema;
  logic [ir_slot_w-1:0] s0_memb;
  logic [ir_slot_w-1:0] s0_slot0;
  logic [ir_slot_w-1:0] s0_slot1;
  lane_mask_t           s0_rd_valid;
  logic                 s0_mema_is0;
  pc_t                  s0_pc0;
  pc_t                  s0_pc1;
  instr_t               s0_instr0;
  instr_t               s0_instr1;

  reg_addr_t            rs1_0;
  reg_addr_t            rs2_0;
  reg_addr_t            rd_0;
  reg_addr_t            rs1_1;
  reg_addr_t            rs2_1;
  reg_addr_t            rd_1;
  logic                 rd_we_0;
  logic                 rd_we_1;
  op_class_e            class_0;
  op_class_e            class_1;

  logic [ir_dec_w-1:0]  dec_rec0;
  logic [ir_dec_w-1:0]  dec_rec1;
  logic [ir_dec_w-1:0]  s1_mema;
  logic [ir_dec_w-1:0]  s1_memb;
  lane_mask_t           s1_wr_rdy;
  lane_mask_t           s1_wr_mema;
  lane_mask_t           s1_wr_memb;
  logic [2:0]           ira_class_bits;
  logic [2:0]           irb_class_bits;

  ir_pair_fifo #(.Width(ir_slot_w)) u_s0_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (ir_flush_i),
    .wr_valid_i (us_valid_i),
    .wr_data0_i ({us_pc0_i, us_instr0_i}),
    .wr_data1_i ({us_pc1_i, us_instr1_i}),
    .wr_rdy_o   (ir_rdy_o),
    .rd_rdy_i   (s1_wr_rdy),
    .rd_valid_o (s0_rd_valid),
    .mema_o     (s0_mema),
    .memb_o     (s0_memb),
    .mema_is0_o (s0_mema_is0),
    .wr_mema_o  (),
    .wr_memb_o  ()
  );

  // put the oldest fetch slot on lane 0
  assign s0_slot0 = s0_mema_is0 ? s0_mema : s0_memb;
  assign s0_slot1 = s0_mema_is0 ? s0_memb : s0_mema;
  assign {s0_pc0, s0_instr0} = s0_slot0;
  assign {s0_pc1, s0_instr1} = s0_slot1;

  ir_field_decoder u_dec0 (
    .instr_i    (s0_instr0),
    .rs1_o      (rs1_0),
    .rs2_o      (rs2_0),
    .rd_o       (rd_0),
    .rd_we_o    (rd_we_0),
    .op_class_o (class_0)
  );

  ir_field_decoder u_dec1 (
    .instr_i    (s0_instr1),
    .rs1_o      (rs1_1),
    .rs2_o      (rs2_1),
    .rd_o       (rd_1),
    .rd_we_o    (rd_we_1),
    .op_class_o (class_1)
  );

  assign rf_raddr_p0_o[0] = rs1_0;
  assign rf_raddr_p0_o[1] = rs2_0;
  assign rf_raddr_p1_o[0] = rs1_1;
  assign rf_raddr_p1_o[1] = rs2_1;

  assign dec_rec0 = {s0_pc0, rs1_0, rs2_0, rd_0, rd_we_0, class_0};
  assign dec_rec1 = {s0_pc1, rs1_1, rs2_1, rd_1, rd_we_1, class_1};

  ir_pair_fifo #(.Width(ir_dec_w)) u_s1_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (ir_flush_i),
    .wr_valid_i (s0_rd_valid),
    .wr_data0_i (dec_rec0),
    .wr_data1_i (dec_rec1),
    .wr_rdy_o   (s1_wr_rdy),
    .rd_rdy_i   (ds_rdy_i),
    .rd_valid_o (ir_valid_o),
    .mema_o     (s1_mema),
    .memb_o     (s1_memb),
    .mema_is0_o (ira_is0_o),
    .wr_mema_o  (s1_wr_mema),
    .wr_memb_o  (s1_wr_memb)
  );

  assign {ira_pc_o, ira_rs1_o, ira_rs2_o, ira_rd_o, ira_rd_we_o, ira_class_bits} = s1_mema;
  assign {irb_pc_o, irb_rs1_o, irb_rs2_o, irb_rd_o, irb_rd_we_o, irb_class_bits} = s1_memb;
  assign ira_class_o = op_class_e'(ira_class_bits);
  assign irb_class_o = op_class_e'(irb_class_bits);

  // operands follow the physical entries of the output buffer
  ir_operand_hold u_hold_a (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_mem_i    (s1_wr_mema),
    .rs1_l0_i    (rs1_0),
    .rs2_l0_i    (rs2_0),
    .rs1_l1_i    (rs1_1),
    .rs2_l1_i    (rs2_1),
    .rdata0_l0_i (rf_rdata_p0_i[0]),
    .rdata1_l0_i (rf_rdata_p0_i[1]),
    .rdata0_l1_i (rf_rdata_p1_i[0]),
    .rdata1_l1_i (rf_rdata_p1_i[1]),
    .waddr0_i    (rf_waddr0_i),
    .waddr1_i    (rf_waddr1_i),
    .waddr2_i    (rf_waddr2_i),
    .wdata0_i    (rf_wdata0_i),
    .wdata1_i    (rf_wdata1_i),
    .wdata2_i    (rf_wdata2_i),
    .we0_i       (rf_we0_i),
    .we1_i       (rf_we1_i),
    .we2_i       (rf_we2_i),
    .op0_o       (ira_op0_o),
    .op1_o       (ira_op1_o)
  );

  ir_operand_hold u_hold_b (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_mem_i    (s1_wr_memb),
    .rs1_l0_i    (rs1_0),
    .rs2_l0_i    (rs2_0),
    .rs1_l1_i    (rs1_1),
    .rs2_l1_i    (rs2_1),
    .rdata0_l0_i (rf_rdata_p0_i[0]),
    .rdata1_l0_i (rf_rdata_p0_i[1]),
    .rdata0_l1_i (rf_rdata_p1_i[0]),
    .rdata1_l1_i (rf_rdata_p1_i[1]),
    .waddr0_i    (rf_waddr0_i),
    .waddr1_i    (rf_waddr1_i),
    .waddr2_i    (rf_waddr2_i),
    .wdata0_i    (rf_wdata0_i),
    .wdata1_i    (rf_wdata1_i),
    .wdata2_i    (rf_wdata2_i),
    .we0_i       (rf_we0_i),
    .we1_i       (rf_we1_i),
    .we2_i       (rf_we2_i),
    .op0_o       (irb_op0_o),
    .op1_o       (irb_op1_o)
  );

endmodule

// ==== testbench/tb_ir_stage.sv ====
// ----------------------------------------
// testbench for the instruction register
// stage: directed tests, regfile model,
// output collector and watchdog
// ----------------------------------------
`timescale 1ns/100ps

module tb_ir_stage;
  import ir_pkg::*;

  localparam int NumTests = 5;

  typedef struct packed {
    pc_t       pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      we;
    op_class_e cls;
  } rec_t;

  logic       clk_i;
  logic       rst_ni;
  logic       ir_flush_i;
  lane_mask_t us_valid_i;
  pc_t        us_pc0_i;
  pc_t        us_pc1_i;
  instr_t     us_instr0_i;
  instr_t     us_instr1_i;
  lane_mask_t ir_rdy_o;
  reg_addr_t  rf_raddr_p0_o [2];
  reg_addr_t  rf_raddr_p1_o [2];
  xlen_t      rf_rdata_p0_i [2];
  xlen_t      rf_rdata_p1_i [2];
  reg_addr_t  rf_waddr0_i;
  reg_addr_t  rf_waddr1_i;
  reg_addr_t  rf_waddr2_i;
  xlen_t      rf_wdata0_i;
  xlen_t      rf_wdata1_i;
  xlen_t      rf_wdata2_i;
  logic       rf_we0_i;
  logic       rf_we1_i;
  logic       rf_we2_i;
  lane_mask_t ds_rdy_i;
  lane_mask_t ir_valid_o;
  logic       ira_is0_o;
  pc_t        ira_pc_o;
  reg_addr_t  ira_rs1_o;
  reg_addr_t  ira_rs2_o;
  reg_addr_t  ira_rd_o;
  logic       ira_rd_we_o;
  op_class_e  ira_class_o;
  pc_t        irb_pc_o;
  reg_addr_t  irb_rs1_o;
  reg_addr_t  irb_rs2_o;
  reg_addr_t  irb_rd_o;
  logic       irb_rd_we_o;
  op_class_e  irb_class_o;
  xlen_t      ira_op0_o;
  xlen_t      ira_op1_o;
  xlen_t      irb_op0_o;
  xlen_t      irb_op1_o;

  xlen_t      regs [32];
  integer     seed;
  string      test_name;
  pc_t        next_pc;
  pc_t        pend_pc[$];
  instr_t     pend_ins[$];
  rec_t       pend_rec[$];
  rec_t       exp_q[$];
  int         exp_base;
  int         out_idx;
  int         chk_errors;
  int         col_errors;
  int         err_mark;
  int         pass_cnt;
  int         fail_cnt;
  lane_mask_t take;

  ir_stage u_ir_stage (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // regfile model with combinational reads
  assign rf_rdata_p0_i[0] = regs[rf_raddr_p0_o[0]];
  assign rf_rdata_p0_i[1] = regs[rf_raddr_p0_o[1]];
  assign rf_rdata_p1_i[0] = regs[rf_raddr_p1_o[0]];
  assign rf_rdata_p1_i[1] = regs[rf_raddr_p1_o[1]];

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= (k == 0) ? '0 : (32'hA500_0000 ^ (32'(k) * 32'h0001_0203));
      end
    end else begin
      // port 2 is written last and so wins
      if (rf_we0_i) regs[rf_waddr0_i] <= rf_wdata0_i;
      if (rf_we1_i) regs[rf_waddr1_i] <= rf_wdata1_i;
      if (rf_we2_i) regs[rf_waddr2_i] <= rf_wdata2_i;
    end
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // RV32I major opcodes
  function automatic instr_t make_instr(input op_class_e c, input reg_addr_t rs1,
                                        input reg_addr_t rs2, input reg_addr_t rd);
    instr_t ins;
    ins = rnd();
    ins[19:15] = rs1;
    ins[24:20] = rs2;
    ins[11:7] = rd;
    case (c)
      OP_REG:    ins[6:0] = 7'b0110011;
      OP_IMM:    ins[6:0] = 7'b0010011;
      OP_LOAD:   ins[6:0] = 7'b0000011;
      OP_STORE:  ins[6:0] = 7'b0100011;
      OP_BRANCH: ins[6:0] = 7'b1100011;
      OP_LUI:    ins[6:0] = 7'b0110111;
      OP_JAL:    ins[6:0] = 7'b1101111;
      default:   ins[6:0] = 7'b1110011;
    endcase
    return ins;
  endfunction

  // fields a class does not use are expected as x0
  function automatic rec_t expect_rec(input pc_t pc, input op_class_e c, input reg_addr_t rs1,
                                      input reg_addr_t rs2, input reg_addr_t rd);
    rec_t r;
    logic u1;
    logic u2;
    logic ud;
    u1 = c inside {OP_REG, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH};
    u2 = c inside {OP_REG, OP_STORE, OP_BRANCH};
    ud = c inside {OP_REG, OP_IMM, OP_LOAD, OP_LUI, OP_JAL};
    r.pc = pc;
    r.cls = c;
    r.rs1 = u1 ? rs1 : '0;
    r.rs2 = u2 ? rs2 : '0;
    r.rd = ud ? rd : '0;
    r.we = ud && (rd != '0);
    return r;
  endfunction

  task automatic add_instr(input op_class_e c, input reg_addr_t rs1, input reg_addr_t rs2,
                           input reg_addr_t rd);
    pend_pc.push_back(next_pc);
    pend_ins.push_back(make_instr(c, rs1, rs2, rd));
    pend_rec.push_back(expect_rec(next_pc, c, rs1, rs2, rd));
    next_pc = next_pc + 4;
  endtask

  task automatic queue_random(input int n, input int maxreg);
    logic [31:0] r;
    for (int k = 0; k < n; k++) begin
      r = rnd();
      add_instr(op_class_e'(r[2:0]), 5'(r[12:8] % (maxreg + 1)),
                5'(r[20:16] % (maxreg + 1)), r[28:24]);
    end
  endtask

  // lanes go out in order and never beyond ir_rdy_o
  task automatic feed();
    while (pend_pc.size() > 0) begin
      @(posedge clk_i);
      #2;
      us_valid_i = 2'b00;
      if (ir_rdy_o[0]) begin
        us_pc0_i = pend_pc.pop_front();
        us_instr0_i = pend_ins.pop_front();
        exp_q.push_back(pend_rec.pop_front());
        us_valid_i = 2'b01;
        if (ir_rdy_o[1] && pend_pc.size() > 0) begin
          us_pc1_i = pend_pc.pop_front();
          us_instr1_i = pend_ins.pop_front();
          exp_q.push_back(pend_rec.pop_front());
          us_valid_i = 2'b11;
        end
      end
    end
    @(posedge clk_i);
    #2;
    us_valid_i = 2'b00;
  endtask

  // mode 0 takes both, 1 random 01/11, 2 mostly stalled
  task automatic drain(input int mode);
    int cnt;
    logic [31:0] r;
    cnt = 0;
    while ((pend_pc.size() > 0 || out_idx < exp_q.size()) && cnt < 300) begin
      @(posedge clk_i);
      #2;
      r = rnd();
      if (mode == 0) ds_rdy_i = 2'b11;
      else if (mode == 1) ds_rdy_i = r[0] ? 2'b11 : 2'b01;
      else ds_rdy_i = (r[1:0] == 2'b00) ? 2'b11 : 2'b00;
      cnt++;
    end
    ds_rdy_i = 2'b00;
    if (out_idx < exp_q.size()) begin
      chk_errors++;
      $display("[%s] drain timed out, %0d instructions never issued", test_name,
               exp_q.size() - out_idx);
    end
  endtask

  task automatic write_burst(input int n);
    logic [31:0] r;
    for (int k = 0; k < n; k++) begin
      @(posedge clk_i);
      #2;
      r = rnd();
      rf_we0_i = r[0];
      rf_we1_i = r[1];
      rf_we2_i = r[2];
      rf_waddr0_i = 5'(1 + r[10:8] % 7);
      rf_waddr1_i = 5'(1 + r[14:12] % 7);
      rf_waddr2_i = 5'(1 + r[18:16] % 7);
      rf_wdata0_i = rnd();
      rf_wdata1_i = rnd();
      rf_wdata2_i = rnd();
      // all three ports on one register
      if (k % 4 == 3) begin
        rf_we0_i = 1'b1;
        rf_we1_i = 1'b1;
        rf_we2_i = 1'b1;
        rf_waddr1_i = rf_waddr0_i;
        rf_waddr2_i = rf_waddr0_i;
      end
    end
    @(posedge clk_i);
    #2;
    rf_we0_i = 1'b0;
    rf_we1_i = 1'b0;
    rf_we2_i = 1'b0;
  endtask

  task automatic wait_full();
    int cnt;
    cnt = 0;
    while (ir_rdy_o != 2'b00 && cnt < 20) begin
      @(posedge clk_i);
      #2;
      cnt++;
    end
    if (ir_rdy_o != 2'b00) begin
      chk_errors++;
      $display("** Error [%s] ir_rdy_o: expected 00, actual %b", test_name, ir_rdy_o);
    end
    if (ir_valid_o != 2'b11) begin
      chk_errors++;
      $display("** Error [%s] ir_valid_o: expected 11, actual %b", test_name, ir_valid_o);
    end
  endtask

  task automatic check_entry(input logic use_b);
    rec_t act;
    rec_t want;
    xlen_t op0;
    xlen_t op1;
    if (use_b) begin
      act = {irb_pc_o, irb_rs1_o, irb_rs2_o, irb_rd_o, irb_rd_we_o, irb_class_o};
      op0 = irb_op0_o;
      op1 = irb_op1_o;
    end else begin
      act = {ira_pc_o, ira_rs1_o, ira_rs2_o, ira_rd_o, ira_rd_we_o, ira_class_o};
      op0 = ira_op0_o;
      op1 = ira_op1_o;
    end
    if (out_idx >= exp_q.size()) begin
      col_errors++;
      $display("[%s] an instruction was issued that was never sent, pc %h", test_name, act.pc);
    end else begin
      want = exp_q[out_idx];
      out_idx++;
      if (act !== want) begin
        col_errors++;
        $display("** Error [%s] record: expected %h, actual %h", test_name, want, act);
      end
      if (op0 !== regs[want.rs1]) begin
        col_errors++;
        $display("** Error [%s] op0: expected %h, actual %h", test_name, regs[want.rs1], op0);
      end
      if (op1 !== regs[want.rs2]) begin
        col_errors++;
        $display("** Error [%s] op1: expected %h, actual %h", test_name, regs[want.rs2], op1);
      end
    end
  endtask

  // sampled mid-cycle before the take edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (out_idx < exp_base) out_idx = exp_base;
      take = ir_valid_o & ds_rdy_i;
      if (take[0]) check_entry(!ira_is0_o);
      if (take[1]) check_entry(ira_is0_o);
    end
  end

  task automatic begin_test(input string name);
    test_name = name;
    err_mark = chk_errors + col_errors;
  endtask

  task automatic end_test();
    int n;
    n = chk_errors + col_errors - err_mark;
    if (n == 0) begin
      pass_cnt++;
      $display("%s: passed", test_name);
    end else begin
      fail_cnt++;
      $display("%s: failed with %0d errors", test_name, n);
    end
  endtask

  task automatic check_reset_state();
    begin_test("reset");
    @(posedge clk_i);
    #2;
    if (ir_valid_o != 2'b00) begin
      chk_errors++;
      $display("** Error [%s] ir_valid_o: expected 00, actual %b", test_name, ir_valid_o);
    end
    if (ir_rdy_o != 2'b11) begin
      chk_errors++;
      $display("** Error [%s] ir_rdy_o: expected 11, actual %b", test_name, ir_rdy_o);
    end
    end_test();
  endtask

  task automatic pass_all_classes();
    logic [31:0] r;
    begin_test("classes");
    for (int k = 0; k < 8; k++) begin
      r = rnd();
      add_instr(op_class_e'(3'(k)), r[4:0], r[9:5], r[14:10] | 5'd1);
    end
    add_instr(OP_REG, 5'd3, 5'd4, 5'd0);
    add_instr(OP_JAL, 5'd0, 5'd0, 5'd0);
    queue_random(8, 31);
    fork
      feed();
      drain(0);
    join
    end_test();
  endtask

  task automatic track_operands();
    begin_test("operands");
    queue_random(14, 7);
    fork
      feed();
      write_burst(60);
      drain(2);
    join
    end_test();
  endtask

  task automatic hold_back_pressure();
    begin_test("backpressure");
    ds_rdy_i = 2'b00;
    queue_random(4, 31);
    feed();
    wait_full();
    queue_random(6, 31);
    fork
      feed();
      drain(1);
    join
    end_test();
  endtask

  task automatic flush_both_buffers();
    begin_test("flush");
    ds_rdy_i = 2'b00;
    queue_random(4, 31);
    feed();
    wait_full();
    ir_flush_i = 1'b1;
    exp_base = exp_q.size();
    @(posedge clk_i);
    #2;
    ir_flush_i = 1'b0;
    if (ir_valid_o != 2'b00) begin
      chk_errors++;
      $display("** Error [%s] ir_valid_o: expected 00, actual %b", test_name, ir_valid_o);
    end
    if (ir_rdy_o != 2'b11) begin
      chk_errors++;
      $display("** Error [%s] ir_rdy_o: expected 11, actual %b", test_name, ir_rdy_o);
    end
    queue_random(4, 31);
    fork
      feed();
      drain(0);
    join
    end_test();
  endtask

  initial begin
    #(NumTests * 400 * 20);
    $display("watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    seed = 32'h4222a8a8;
    next_pc = 32'h0000_1000;
    exp_base = 0;
    chk_errors = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    rst_ni = 1'b0;
    ir_flush_i = 1'b0;
    us_valid_i = 2'b00;
    us_pc0_i = '0;
    us_pc1_i = '0;
    us_instr0_i = '0;
    us_instr1_i = '0;
    ds_rdy_i = 2'b00;
    rf_waddr0_i = '0;
    rf_waddr1_i = '0;
    rf_waddr2_i = '0;
    rf_wdata0_i = '0;
    rf_wdata1_i = '0;
    rf_wdata2_i = '0;
    rf_we0_i = 1'b0;
    rf_we1_i = 1'b0;
    rf_we2_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    check_reset_state();
    pass_all_classes();
    track_operands();
    hold_back_pressure();
    flush_both_buffers();
    repeat (4) @(posedge clk_i);
    $display("%0d tests passed, %0d failed, %0d errors", pass_cnt, fail_cnt,
             chk_errors + col_errors);
    if (fail_cnt == 0 && chk_errors + col_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    out_idx = 0;
    col_errors = 0;
  end

endmodule

// ==== tb.f ====
+incdir+include
verilog/ir_pkg.sv
verilog/ir_pair_fifo.sv
verilog/ir_field_decoder.sv
verilog/ir_operand_hold.sv
verilog/ir_stage.sv
testbench/tb_ir_stage.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the instruction register stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  -f tb.f --top-module tb_ir_stage -o sim_tb_ir_stage

out=$(./obj_dir/sim_tb_ir_stage)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
else
  exit 1
fi
